/* compile.f */
source/periph_pkg.sv
source/tc_bus_if.sv
source/periph_bridge.sv
source/tc_regs.sv
source/tc_fsm.sv
source/tc_counter.sv
source/tc.sv
source/mips_periph.sv
sim/tb_mips_periph_assert.sv
sim/tb_mips_periph.sv

/* run_sim.sh */
#!/bin/sh
# build and run the testbench with verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal -f compile.f \
    --top-module tb_mips_periph -o tb_mips_periph
./obj_dir/tb_mips_periph > sim.log 2>&1 || true
cat sim.log

if grep -q "TESTBENCH PASSED" sim.log; then
    exit 0
fi
echo "simulation did not pass, see sim.log"
exit 1

/* sim/tb_mips_periph.sv */
`timescale 1ns/1ps

module tb_mips_periph;
    import periph_pkg::*;

    // transactions per test and worst-case cycles per transaction
    localparam int route_n     = 300;
    localparam int route_cyc   = 1;
    localparam int regs_n      = 12;
    localparam int regs_cyc    = 8;
    localparam int oneshot_n   = 4;
    localparam int oneshot_cyc = 80;
    localparam int reload_n    = 2;
    localparam int reload_cyc  = 130;
    localparam int misc_n      = 3;
    localparam int misc_cyc    = 60;
    localparam int limit_cyc   = 2 * (16 + route_n * route_cyc + regs_n * regs_cyc
                                 + oneshot_n * oneshot_cyc + reload_n * reload_cyc
                                 + misc_n * misc_cyc);

    logic       clk;
    logic       reset;
    logic       interrupt;
    data_t      cpu_m_data_addr;
    data_t      cpu_m_data_wdata;
    byteen_t    cpu_m_data_byteen;
    data_t      cpu_m_data_rdata;
    data_t      m_data_addr;
    data_t      m_data_wdata;
    byteen_t    m_data_byteen;
    data_t      m_data_rdata;
    data_t      m_int_addr;
    byteen_t    m_int_byteen;
    logic [2:0] hw_int;

    // reference model, one entry per timer
    logic [3:0] md_ctrl [2];
    data_t      md_preset [2];
    data_t      md_count [2];
    tc_state_e  md_state [2];
    logic       md_pend [2];

    data_t seed = 32'h001f2385;
    logic  ext_random;   // random bits on the external line
    string test_name;
    int    test_err;
    int    n_err;
    int    tests_ok;
    int    tests_bad;

    mips_periph mips_periph_i (.*);

    always #5 clk = ~clk;

    function automatic data_t lcg_next();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    function automatic logic in_tc(input data_t a, input data_t base);
        return a >= base && a < base + tc_window;
    endfunction

    function automatic logic in_int(input data_t a);
        return a >= int_base && a < int_base + int_window;
    endfunction

    function automatic data_t tc_base(input int t);
        return (t == 0) ? tc0_base : tc1_base;
    endfunction

    // one clock edge of one timer, from the bus values held before the edge
    task automatic model_step(input int t);
        tc_state_e st;
        data_t     off;
        logic      wr;
        logic      en;
        logic      oneshot;
        st      = md_state[t];
        off     = (cpu_m_data_addr - tc_base(t)) >> 2;
        wr      = (|cpu_m_data_byteen) && in_tc(cpu_m_data_addr, tc_base(t));
        en      = md_ctrl[t][ctrl_en_bit];
        oneshot = md_ctrl[t][ctrl_mode_hi:ctrl_mode_lo] == 2'd0;
        case (st)
            st_idle: begin
                if (en) md_state[t] = st_load;
            end
            st_load: begin
                md_state[t] = en ? st_cnt : st_idle;
                if (en) md_count[t] = md_preset[t];
            end
            st_cnt: begin
                if (!en) begin
                    md_state[t] = st_idle;   // count holds
                end else if (md_count[t] <= 1) begin
                    md_count[t] = 0;
                    md_state[t] = st_int;
                end else begin
                    md_count[t] = md_count[t] - 1;
                end
            end
            default: md_state[t] = (oneshot || !en) ? st_idle : st_load;
        endcase
        if (st == st_int && oneshot) begin
            md_pend[t] = 1'b1;
        end else if (wr && off == 0) begin
            md_pend[t] = 1'b0;
        end
        if (wr && off == 0) begin
            md_ctrl[t] = cpu_m_data_wdata[3:0];
        end else if (st == st_int && oneshot) begin
            md_ctrl[t][ctrl_en_bit] = 1'b0;
        end
        if (wr && off == 1) md_preset[t] = cpu_m_data_wdata;
    endtask

    always @(posedge clk) begin
        if (reset) begin
            for (int t = 0; t < 2; t++) begin
                md_ctrl[t]   = '0;
                md_preset[t] = '0;
                md_count[t]  = '0;
                md_state[t]  = st_idle;
                md_pend[t]   = 1'b0;
            end
        end else begin
            for (int t = 0; t < 2; t++) model_step(t);
        end
    end

    function automatic data_t rdata_model();
        data_t a;
        data_t off;
        int    t;
        a = cpu_m_data_addr;
        if (in_int(a)) return '0;
        if (in_tc(a, tc0_base)) begin
            t = 0;
        end else if (in_tc(a, tc1_base)) begin
            t = 1;
        end else begin
            return m_data_rdata;
        end
        off = (a - tc_base(t)) >> 2;
        case (off)
            0:       return data_t'(md_ctrl[t]);
            1:       return md_preset[t];
            2:       return md_count[t];
            default: return '0;
        endcase
    endfunction

    function automatic logic [2:0] irq_model();
        logic [2:0] v;
        v[2] = interrupt;
        for (int t = 0; t < 2; t++) begin
            v[t] = md_ctrl[t][ctrl_im_bit] && (md_state[t] == st_int || md_pend[t]);
        end
        return v;
    endfunction

    task automatic check_data(input string what, input data_t exp, input data_t act);
        if (act !== exp) begin
            $display("** Error %s %s: expected %h actual %h", test_name, what, exp, act);
            test_err++;
        end
    endtask

    task automatic check_byteen(input string what, input byteen_t exp, input byteen_t act);
        if (act !== exp) begin
            $display("** Error %s %s: expected %h actual %h", test_name, what, exp, act);
            test_err++;
        end
    endtask

    task automatic check_irq(input string what, input logic [2:0] exp, input logic [2:0] act);
        if (act !== exp) begin
            $display("** Error %s %s: expected %b actual %b", test_name, what, exp, act);
            test_err++;
        end
    endtask

    task automatic check_all();
        logic hit;
        logic hit_int;
        hit_int = in_int(cpu_m_data_addr);
        hit = hit_int || in_tc(cpu_m_data_addr, tc0_base) || in_tc(cpu_m_data_addr, tc1_base);
        check_data("m_data_addr", cpu_m_data_addr, m_data_addr);
        check_data("m_data_wdata", cpu_m_data_wdata, m_data_wdata);
        check_byteen("m_data_byteen", hit ? 4'h0 : cpu_m_data_byteen, m_data_byteen);
        check_data("m_int_addr", hit_int ? cpu_m_data_addr : 32'h0, m_int_addr);
        check_byteen("m_int_byteen", hit_int ? cpu_m_data_byteen : 4'h0, m_int_byteen);
        check_data("rdata", rdata_model(), cpu_m_data_rdata);
        check_irq("hw_int", irq_model(), hw_int);
    endtask

    // one bus cycle, outputs checked at the falling edge
    task automatic drive(input data_t a, input data_t d, input byteen_t be);
        data_t r;
        r = lcg_next();
        @(posedge clk);
        cpu_m_data_addr   <= a;
        cpu_m_data_wdata  <= d;
        cpu_m_data_byteen <= be;
        m_data_rdata      <= lcg_next();
        interrupt         <= ext_random & r[24];
        @(negedge clk);
        check_all();
    endtask

    task automatic write_reg(input int t, input int off, input data_t d);
        drive(tc_base(t) + data_t'(off * 4), d, 4'hf);
    endtask

    task automatic read_reg(input int t, input int off);
        drive(tc_base(t) + data_t'(off * 4), lcg_next(), 4'h0);
    endtask

    task automatic idle();
        data_t r;
        r = lcg_next();
        drive({20'd0, r[21:12], 2'b00}, lcg_next(), 4'h0);   // plain memory read
    endtask

    task automatic stop_timers();
        write_reg(0, 0, 32'h0);
        write_reg(1, 0, 32'h0);
        idle();
    endtask

    task automatic begin_test(input string name);
        test_name = name;
        test_err  = 0;
        stop_timers();
    endtask

    task automatic end_test();
        if (test_err == 0) begin
            $display("test %s: ok", test_name);
            tests_ok++;
        end else begin
            $display("test %s: %0d errors", test_name, test_err);
            tests_bad++;
        end
        n_err += test_err;
    endtask

    task automatic route_addresses();
        data_t r;
        data_t a;
        begin_test("address routing");
        ext_random = 1'b1;
        repeat (route_n) begin
            r = lcg_next();
            case (r[31:30])   // around each window, or anywhere
                2'd0:    a = tc0_base - 32'd4 + data_t'(r[20:16]);
                2'd1:    a = tc1_base - 32'd4 + data_t'(r[20:16]);
                2'd2:    a = int_base - 32'd4 + data_t'(r[20:16]);
                default: a = lcg_next();
            endcase
            drive(a, lcg_next(), r[25] ? r[11:8] : 4'h0);
        end
        ext_random = 1'b0;
        end_test();
    endtask

    task automatic access_registers();
        begin_test("register access");
        for (int t = 0; t < 2; t++) begin
            repeat (6) begin
                write_reg(t, 0, lcg_next() & ~32'h1);   // enable stays clear
                write_reg(t, 1, lcg_next());
                write_reg(t, 2, lcg_next());   // count is read only
                for (int off = 0; off < 4; off++) read_reg(t, off);
            end
        end
        end_test();
    endtask

    task automatic oneshot_irq();
        data_t      p;
        int         n;
        logic [2:0] bit_t;
        begin_test("one-shot interrupt");
        for (int t = 0; t < 2; t++) begin
            repeat (2) begin
                p     = 1 + (lcg_next() >> 16) % 63;
                n     = (p > 1 ? p : 1) + 2;
                bit_t = (t == 0) ? 3'b001 : 3'b010;
                write_reg(t, 1, p);
                write_reg(t, 0, 32'h9);   // enable, mode 0, im
                for (int k = 0; k <= n + 3; k++) begin
                    idle();
                    check_irq("irq edge", (k >= n) ? bit_t : 3'b000, hw_int);
                end
                read_reg(t, 0);
                check_data("enable cleared", 32'h8, cpu_m_data_rdata);
                check_irq("irq held", bit_t, hw_int);
                write_reg(t, 0, 32'h0);
                idle();
                check_irq("irq after ctrl write", 3'b000, hw_int);
            end
        end
        end_test();
    endtask

    task automatic reload_period();
        data_t      p;
        data_t      r;
        int         per;
        logic [2:0] bit_t;
        begin_test("auto-reload period");
        for (int t = 0; t < 2; t++) begin
            p     = 1 + (lcg_next() >> 16) % 20;
            per   = p + 2;
            bit_t = (t == 0) ? 3'b001 : 3'b010;
            write_reg(t, 1, p);
            write_reg(t, 0, 32'hb);   // enable, mode 1, im
            for (int k = 0; k <= 5 * per; k++) begin
                r = lcg_next();
                if (r[20]) begin
                    read_reg(t, 2);   // count against the model
                end else begin
                    idle();
                end
                check_irq("irq period", (k > 0 && k % per == 0) ? bit_t : 3'b000, hw_int);
            end
            write_reg(t, 0, 32'h0);
        end
        end_test();
    endtask

    task automatic mask_disable_ext();
        data_t p;
        int    w;
        begin_test("mask, disable and external line");
        p = 1 + (lcg_next() >> 16) % 10;
        write_reg(0, 1, p);
        write_reg(0, 0, 32'h3);   // reload with im clear
        repeat (3 * (p + 2)) begin
            idle();
            check_irq("masked irq", 3'b000, hw_int);
        end
        write_reg(0, 0, 32'h0);
        p = 40 + (lcg_next() >> 16) % 20;
        w = 5 + (lcg_next() >> 16) % 16;
        write_reg(1, 1, p);
        write_reg(1, 0, 32'h9);
        repeat (w) idle();
        write_reg(1, 0, 32'h0);
        // disable lands w+1 edges after enable, one last decrement included
        repeat (4) begin
            read_reg(1, 2);
            check_data("frozen count", p - w + 1, cpu_m_data_rdata);
        end
        ext_random = 1'b1;
        repeat (40) begin
            idle();
            check_irq("external line", {interrupt, 2'b00}, hw_int);
        end
        ext_random = 1'b0;
        end_test();
    endtask

    initial begin
        clk               = 1'b0;
        reset             = 1'b1;
        interrupt         = 1'b0;
        cpu_m_data_addr   = '0;
        cpu_m_data_wdata  = '0;
        cpu_m_data_byteen = '0;
        m_data_rdata      = '0;
        ext_random        = 1'b0;
        test_err          = 0;
        n_err             = 0;
        tests_ok          = 0;
        tests_bad         = 0;
        repeat (16) @(posedge clk);
        reset <= 1'b0;
        route_addresses();
        access_registers();
        oneshot_irq();
        reload_period();
        mask_disable_ext();
        $display("tests passed %0d failed %0d, check errors %0d", tests_ok, tests_bad, n_err);
        if (tests_bad == 0 && n_err == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

    // watchdog
    initial begin
        #(limit_cyc * 10);
        $display("watchdog: tests did not finish within %0d cycles", limit_cyc);
        $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

/* sim/tb_mips_periph_assert.sv */
`timescale 1ns/1ps

module tc_assert (
    input logic                  clk,
    input logic                  reset,
    input logic [3:0]            wr_sel,   // {mem, int, tc1, tc0}
    input logic [1:0]            im,
    input logic [1:0]            irq,
    input periph_pkg::tc_state_e st0,
    input periph_pkg::tc_state_e st1
);
    import periph_pkg::*;

    // a cpu store lands in exactly one place or nowhere
    a_one_target: assert property (@(posedge clk) disable iff (reset) $onehot0(wr_sel))
        else $error("more than one write target active: %b", wr_sel);

    a_irq0_im: assert property (@(posedge clk) disable iff (reset) $rose(irq[0]) |-> im[0])
        else $error("tc0 irq rose while im is clear");

    a_irq1_im: assert property (@(posedge clk) disable iff (reset) $rose(irq[1]) |-> im[1])
        else $error("tc1 irq rose while im is clear");

    a_load0: assert property (@(posedge clk) disable iff (reset)
        st0 == st_load |=> (st0 == st_cnt || st0 == st_idle))
        else $error("tc0 left load for a state other than cnt or idle");

    a_load1: assert property (@(posedge clk) disable iff (reset)
        st1 == st_load |=> (st1 == st_cnt || st1 == st_idle))
        else $error("tc1 left load for a state other than cnt or idle");

endmodule

bind mips_periph tc_assert tc_assert_i (
    .clk    (clk),
    .reset  (reset),
    .wr_sel ({|m_data_byteen, |m_int_byteen, tc1_bus.we, tc0_bus.we}),
    .im     ({tc1_i.im, tc0_i.im}),
    .irq    ({tc1_irq, tc0_irq}),
    .st0    (tc0_i.fsm_i.state_q),
    .st1    (tc1_i.fsm_i.state_q)
);

/* source/mips_periph.sv */
`timescale 1ns/1ps

module mips_periph (
    input  logic                clk,
    input  logic                reset,
    input  logic                interrupt,   // external interrupt line

    // cpu m stage data bus
    input  periph_pkg::data_t   cpu_m_data_addr,
    input  periph_pkg::data_t   cpu_m_data_wdata,
    input  periph_pkg::byteen_t cpu_m_data_byteen,
    output periph_pkg::data_t   cpu_m_data_rdata,

    // data memory
    output periph_pkg::data_t   m_data_addr,
    output periph_pkg::data_t   m_data_wdata,
    output periph_pkg::byteen_t m_data_byteen,
    input  periph_pkg::data_t   m_data_rdata,

    // interrupt generator
    output periph_pkg::data_t   m_int_addr,
    output periph_pkg::byteen_t m_int_byteen,

    output logic [2:0]          hw_int   // {external, tc1, tc0}
);

    logic tc0_irq;
    logic tc1_irq;

    tc_bus_if tc0_bus ();
    tc_bus_if tc1_bus ();

    periph_bridge bridge_i (
        .cpu_addr   (cpu_m_data_addr),
        .cpu_wdata  (cpu_m_data_wdata),
        .cpu_byteen (cpu_m_data_byteen),
        .cpu_rdata  (cpu_m_data_rdata),
        .mem_addr   (m_data_addr),
        .mem_wdata  (m_data_wdata),
        .mem_byteen (m_data_byteen),
        .mem_rdata  (m_data_rdata),
        .int_addr   (m_int_addr),
        .int_byteen (m_int_byteen),
        .tc0        (tc0_bus),
        .tc1        (tc1_bus)
    );

    tc tc0_i (
        .clk   (clk),
        .reset (reset),
        .bus   (tc0_bus),
        .irq   (tc0_irq)
    );

    tc tc1_i (
        .clk   (clk),
        .reset (reset),
        .bus   (tc1_bus),
        .irq   (tc1_irq)
    );

    assign hw_int = {interrupt, tc1_irq, tc0_irq};

endmodule

/* source/tc.sv */
`timescale 1ns/1ps

module tc (
    input  logic    clk,
    input  logic    reset,
    tc_bus_if.timer bus,
    output logic    irq
);
    import periph_pkg::*;

    logic     enable;
    tc_mode_e mode;
    logic     im;
    data_t    preset;
    data_t    count;
    logic     ctrl_write;
    logic     clear_en;
    logic     load;
    logic     dec;
    logic     last;

    // register file, also answers reads on bus.dout
    tc_regs regs_i (
        .clk        (clk),
        .reset      (reset),
        .bus        (bus),
        .clear_en   (clear_en),
        .count      (count),
        .enable     (enable),
        .mode       (mode),
        .im         (im),
        .preset     (preset),
        .ctrl_write (ctrl_write)
    );

    tc_fsm fsm_i (
        .clk        (clk),
        .reset      (reset),
        .enable     (enable),
        .mode       (mode),
        .im         (im),
        .ctrl_write (ctrl_write),
        .last       (last),
        .load       (load),
        .dec        (dec),
        .clear_en   (clear_en),
        .irq        (irq)
    );

    tc_counter counter_i (
        .clk    (clk),
        .reset  (reset),
        .load   (load),
        .dec    (dec),
        .preset (preset),
        .count  (count),
        .last   (last)
    );

endmodule

/* source/tc_counter.sv */
`timescale 1ns/1ps

module tc_counter (
    input  logic              clk,
    input  logic              reset,
    input  logic              load,
    input  logic              dec,
    input  periph_pkg::data_t preset,
    output periph_pkg::data_t count,
    output logic              last
);
    import periph_pkg::*;

    data_t count_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            count_q <= '0;
        end else if (load) begin
            count_q <= preset;
        end else if (dec) begin
            // lands on zero and stays there
            count_q <= last ? '0 : count_q - 1'b1;
        end
    end

    assign last  = (count_q[31:1] == '0);   // 0 or 1
    assign count = count_q;

endmodule

/* source/tc_fsm.sv */
`timescale 1ns/1ps

module tc_fsm (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 enable,
    input  periph_pkg::tc_mode_e mode,
    input  logic                 im,
    input  logic                 ctrl_write,
    input  logic                 last,   // count <= 1
    output logic                 load,
    output logic                 dec,
    output logic                 clear_en,
    output logic                 irq
);
    import periph_pkg::*;

    tc_state_e state_q;
    tc_state_e state_d;
    logic      oneshot;
    logic      pending_q;   // one-shot irq held until ctrl is written

    assign oneshot = (mode == mode_oneshot);

    always_comb begin
        state_d = state_q;
        case (state_q)
            st_idle: begin
                if (enable) state_d = st_load;
            end
            st_load: begin
                state_d = enable ? st_cnt : st_idle;
            end
            st_cnt: begin
                if (!enable) begin
                    state_d = st_idle;   // count freezes
                end else if (last) begin
                    state_d = st_int;
                end
            end
            st_int: begin
                // one-shot stops here, reload starts the next period
                state_d = (oneshot || !enable) ? st_idle : st_load;
            end
            default: state_d = st_idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state_q <= st_idle;
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pending_q <= 1'b0;
        end else if (state_q == st_int && oneshot) begin
            pending_q <= 1'b1;   // a finished count is never lost
        end else if (ctrl_write) begin
            pending_q <= 1'b0;
        end
    end

    assign load     = (state_q == st_load) && enable;
    assign dec      = (state_q == st_cnt) && enable;
    assign clear_en = (state_q == st_int) && oneshot;
    assign irq      = im && ((state_q == st_int) || pending_q);

endmodule

/* source/tc_regs.sv */
`timescale 1ns/1ps

module tc_regs (
    input  logic                 clk,
    input  logic                 reset,
    tc_bus_if.timer              bus,
    input  logic                 clear_en,   // one-shot done, drop enable
    input  periph_pkg::data_t    count,
    output logic                 enable,
    output periph_pkg::tc_mode_e mode,
    output logic                 im,
    output periph_pkg::data_t    preset,
    output logic                 ctrl_write
);
    import periph_pkg::*;

    logic [ctrl_im_bit:0] ctrl_q;   // upper bits read as zero
    data_t                preset_q;
    logic                 preset_write;

    assign ctrl_write   = bus.we && (bus.addr == reg_ctrl);
    assign preset_write = bus.we && (bus.addr == reg_preset);

    always_ff @(posedge clk) begin
        if (reset) begin
            ctrl_q <= '0;
        end else if (ctrl_write) begin
            ctrl_q <= bus.din[ctrl_im_bit:0];   // cpu write wins over clear_en
        end else if (clear_en) begin
            ctrl_q[ctrl_en_bit] <= 1'b0;
        end
    end

    // only picked up at the next load
    always_ff @(posedge clk) begin
        if (reset) begin
            preset_q <= '0;
        end else if (preset_write) begin
            preset_q <= bus.din;
        end
    end

    assign enable = ctrl_q[ctrl_en_bit];
    assign mode   = tc_mode_e'(ctrl_q[ctrl_mode_hi:ctrl_mode_lo]);
    assign im     = ctrl_q[ctrl_im_bit];
    assign preset = preset_q;

    // count writes fall through and are dropped
    always_comb begin
        case (bus.addr)
            reg_ctrl:   bus.dout = data_t'(ctrl_q);
            reg_preset: bus.dout = preset_q;
            reg_count:  bus.dout = count;
            default:    bus.dout = '0;
        endcase
    end

endmodule

/* source/periph_bridge.sv */
`timescale 1ns/1ps

module periph_bridge (
    // cpu side, m stage
    input  periph_pkg::data_t   cpu_addr,
    input  periph_pkg::data_t   cpu_wdata,
    input  periph_pkg::byteen_t cpu_byteen,
    output periph_pkg::data_t   cpu_rdata,

    // data memory
    output periph_pkg::data_t   mem_addr,
    output periph_pkg::data_t   mem_wdata,
    output periph_pkg::byteen_t mem_byteen,
    input  periph_pkg::data_t   mem_rdata,

    // interrupt generator
    output periph_pkg::data_t   int_addr,
    output periph_pkg::byteen_t int_byteen,

    tc_bus_if.bridge            tc0,
    tc_bus_if.bridge            tc1
);
    import periph_pkg::*;

    logic  hit_tc0;
    logic  hit_tc1;
    logic  hit_int;
    logic  hit_dev;   // any peripheral window
    logic  wr;
    data_t tc0_off;
    data_t tc1_off;

    function automatic logic in_window(input data_t addr, input data_t base,
                                       input data_t size);
        return (addr >= base) && (addr < base + size);
    endfunction

    assign hit_tc0 = in_window(cpu_addr, tc0_base, tc_window);
    assign hit_tc1 = in_window(cpu_addr, tc1_base, tc_window);
    assign hit_int = in_window(cpu_addr, int_base, int_window);
    assign hit_dev = hit_tc0 | hit_tc1 | hit_int;

    // timers only see whole-word writes
    assign wr = |cpu_byteen;

    assign tc0_off = cpu_addr - tc0_base;
    assign tc1_off = cpu_addr - tc1_base;

    assign tc0.addr = tc0_off[reg_addr_w+1:2];   // byte offset down to words
    assign tc0.we   = hit_tc0 & wr;
    assign tc0.din  = cpu_wdata;

    assign tc1.addr = tc1_off[reg_addr_w+1:2];
    assign tc1.we   = hit_tc1 & wr;
    assign tc1.din  = cpu_wdata;

    // memory always sees address and data, strobes only outside the windows
    assign mem_addr   = cpu_addr;
    assign mem_wdata  = cpu_wdata;
    assign mem_byteen = hit_dev ? '0 : cpu_byteen;

    assign int_addr   = hit_int ? cpu_addr : '0;
    assign int_byteen = hit_int ? cpu_byteen : '0;

    // read back mux, interrupt window reads as zero
    always_comb begin
        if (hit_tc0) begin
            cpu_rdata = tc0.dout;
        end else if (hit_tc1) begin
            cpu_rdata = tc1.dout;
        end else if (hit_int) begin
            cpu_rdata = '0;
        end else begin
            cpu_rdata = mem_rdata;
        end
    end

endmodule

/* source/tc_bus_if.sv */
`timescale 1ns/1ps

interface tc_bus_if;
    import periph_pkg::*;

    logic [reg_addr_w-1:0] addr;   // word offset inside the timer window
    logic                  we;
    data_t                 din;
    data_t                 dout;   // combinational from addr

    modport bridge (
        output addr,
        output we,
        output din,
        input  dout
    );

    modport timer (
        input  addr,
        input  we,
        input  din,
        output dout
    );

endinterface

/* source/periph_pkg.sv */
package periph_pkg;

    typedef logic [31:0] data_t;   // data and addresses
    typedef logic [3:0]  byteen_t;

    // timer fsm states
    typedef enum logic [1:0] {
        st_idle = 2'd0,
        st_load = 2'd1,
        st_cnt  = 2'd2,
        st_int  = 2'd3
    } tc_state_e;

    // timer modes, codes 2 and 3 behave like reload
    typedef enum logic [1:0] {
        mode_oneshot = 2'd0,
        mode_reload  = 2'd1
    } tc_mode_e;

    // address map
    localparam data_t tc0_base   = 32'h0000_7f00;
    localparam data_t tc1_base   = 32'h0000_7f10;
    localparam data_t int_base   = 32'h0000_7f20;
    localparam data_t tc_window  = 32'd12;   // ctrl, preset, count
    localparam data_t int_window = 32'd4;

    // timer register word offsets
    localparam int reg_addr_w = 2;
    localparam logic [reg_addr_w-1:0] reg_ctrl   = 2'd0;
    localparam logic [reg_addr_w-1:0] reg_preset = 2'd1;
    localparam logic [reg_addr_w-1:0] reg_count  = 2'd2;   // read only

    // ctrl register fields
    localparam int ctrl_en_bit  = 0;
    localparam int ctrl_mode_lo = 1;
    localparam int ctrl_mode_hi = 2;
    localparam int ctrl_im_bit  = 3;   // irq mask, 1 lets irq out

endpackage
